/* chaos_params.svh */
`ifndef CHAOS_PARAMS_SVH
`define CHAOS_PARAMS_SVH

//////////////////////////////////////////////////
// Datapath and key geometry
//////////////////////////////////////////////////

// Operand and result width in bits
`define CHAOS_WIDTH 32

// Key bits per segment, 2 per gate for three gates
`define CHAOS_KEYSIZE 6

// Number of key segments
// Segment 0 serves the low half of the bits, segment 1 the high half
`define CHAOS_KEYSET 2

// Whole key width
`define CHAOS_KEYBITS (`CHAOS_KEYSIZE * `CHAOS_KEYSET)

`endif

/* chaos_pkg.sv */
`include "chaos_params.svh"

package chaos_pkg;

   // Function of one programmable two-input gate
   typedef enum logic [1:0]
   {
      GATE_XOR  = 2'd0,
      GATE_AND  = 2'd1,
      GATE_OR   = 2'd2,
      GATE_XNOR = 2'd3
   } gate_fn_e;

   // Arithmetic operation request
   typedef enum logic
   {
      OP_ADD = 1'b0,
      OP_SUB = 1'b1
   } alu_op_e;

   // Full key, segment 0 in the low bits
   typedef logic [`CHAOS_KEYBITS-1:0] key_t;

endpackage

/* alu_op_if.sv */
`timescale 1ns/1ps

`include "chaos_params.svh"

// One operation request, one per cycle with valid high
// No back-pressure, the consumer must take every request
interface alu_op_if;

   logic                    valid;
   chaos_pkg::alu_op_e      op;
   logic [`CHAOS_WIDTH-1:0] a;
   logic [`CHAOS_WIDTH-1:0] b;

   // Request source side
   modport src
   (
      output valid, op, a, b
   );

   // Pipeline side
   modport dst
   (
      input valid, op, a, b
   );

endinterface

/* adder_chaos.sv */
`timescale 1ns/1ps

`include "chaos_params.svh"

// One-bit full adder with three key-programmed gates
// Correct key fields: g0 XOR, g1 XOR, g2 AND
module adder_chaos
(
   input  logic                      a,
   input  logic                      b,
   input  logic                      c_in,
   input  logic [`CHAOS_KEYSIZE-1:0] key,
   output logic                      sum,
   output logic                      c_out
);

   // Outputs of the three programmable gates
   logic g0;
   logic g1;
   logic g2;

   // Evaluate one gate under its key field
   function automatic logic gate_eval
   (
      input chaos_pkg::gate_fn_e fn,
      input logic                x,
      input logic                y
   );
      logic r;
      case (fn)
         chaos_pkg::GATE_XOR:  r = x ^ y;
         chaos_pkg::GATE_AND:  r = x & y;
         chaos_pkg::GATE_OR:   r = x | y;
         chaos_pkg::GATE_XNOR: r = ~(x ^ y);
         default:              r = x ^ y;
      endcase
      return r;
   endfunction

   // g0 combines the operand bits, propagate term when unlocked
   assign g0 = gate_eval(chaos_pkg::gate_fn_e'(key[1:0]), a, b);

   // g1 folds carry-in into the sum
   assign g1 = gate_eval(chaos_pkg::gate_fn_e'(key[3:2]), g0, c_in);

   // g2 forms the generate term
   assign g2 = gate_eval(chaos_pkg::gate_fn_e'(key[5:4]), a, b);

   assign sum   = g1;
   // Carry rule is fixed, only its terms depend on the key
   assign c_out = g2 | (g0 & c_in);

endmodule

/* add_sub_chaos.sv */
`timescale 1ns/1ps

`include "chaos_params.svh"

// Ripple add/subtract built from chaos adders
// c_in high selects a - b through inverted b and a carry of one
module add_sub_chaos
(
   input  logic [`CHAOS_WIDTH-1:0] a,
   input  logic [`CHAOS_WIDTH-1:0] b,
   input  logic                    c_in,
   input  chaos_pkg::key_t         key,
   output logic [`CHAOS_WIDTH-1:0] sum
);

   // Bit index where segment 1 takes over
   localparam int HALF = `CHAOS_WIDTH / 2;

   // Conditionally inverted b
   logic [`CHAOS_WIDTH-1:0] b_xor;

   // Ripple chain, top carry is dropped
   logic [`CHAOS_WIDTH:0]   carry;

   assign b_xor    = b ^ {`CHAOS_WIDTH{c_in}};
   assign carry[0] = c_in;

   //////////////////////////////////////////////////
   // One chaos adder per bit
   //////////////////////////////////////////////////

   genvar ii;
   generate
      for (ii = 0; ii < `CHAOS_WIDTH; ii = ii + 1)
      begin : g_bit
         // Low half on segment 0, high half on segment 1
         localparam int SEG = (ii < HALF) ? 0 : 1;

         adder_chaos u_fa
         (
            .a     (a[ii]),
            .b     (b_xor[ii]),
            .c_in  (carry[ii]),
            .key   (key[SEG*`CHAOS_KEYSIZE +: `CHAOS_KEYSIZE]),
            .sum   (sum[ii]),
            .c_out (carry[ii+1])
         );
      end
   endgenerate

endmodule

/* key_store.sv */
`timescale 1ns/1ps

`include "chaos_params.svh"

// Key register, written one segment per strobe
module key_store
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      key_wr,
   input  logic                      key_seg,
   input  logic [`CHAOS_KEYSIZE-1:0] key_data,
   output chaos_pkg::key_t           key
);

   // All-zero after reset, which is a locked state
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         key <= '0;
      end
      else if (key_wr)
      begin
         // Overwrite only the addressed segment
         key[key_seg*`CHAOS_KEYSIZE +: `CHAOS_KEYSIZE] <= key_data;
      end
   end

   //////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////

   // Segment address in range on every write
   a_seg_range : assert property
   (
      @(posedge clk) disable iff (!rst_n)
      key_wr |-> (key_seg < `CHAOS_KEYSET)
   );

endmodule

/* alu_stage.sv */
`timescale 1ns/1ps

`include "chaos_params.svh"

// Two-stage pipeline around the locked adder
// Request registered at N, result registered at N+1
module alu_stage
(
   input  logic                    clk,
   input  logic                    rst_n,
   alu_op_if.dst                   req,
   input  chaos_pkg::key_t         key,
   output logic                    res_valid,
   output logic [`CHAOS_WIDTH-1:0] res
);

   // Stage 1 request registers
   logic                    s1_valid;
   chaos_pkg::alu_op_e      s1_op;
   logic [`CHAOS_WIDTH-1:0] s1_a;
   logic [`CHAOS_WIDTH-1:0] s1_b;

   // Adder output during the second cycle
   logic [`CHAOS_WIDTH-1:0] sum_w;

   //////////////////////////////////////////////////
   // Stage 1
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         s1_valid <= 1'b0;
      else
         s1_valid <= req.valid;
   end

   // Operands held until the next request
   always_ff @(posedge clk)
   begin
      if (req.valid)
      begin
         s1_op <= req.op;
         s1_a  <= req.a;
         s1_b  <= req.b;
      end
   end

   // Key is sampled live, so a fresh write applies here
   add_sub_chaos u_add_sub
   (
      .a    (s1_a),
      .b    (s1_b),
      .c_in (s1_op == chaos_pkg::OP_SUB),
      .key  (key),
      .sum  (sum_w)
   );

   //////////////////////////////////////////////////
   // Stage 2
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         res_valid <= 1'b0;
         res       <= '0;
      end
      else
      begin
         res_valid <= s1_valid;
         // Result holds between operations
         if (s1_valid)
            res <= sum_w;
      end
   end

   // Result strobe exactly one cycle behind stage 1
   a_res_follows : assert property
   (
      @(posedge clk) disable iff (!rst_n)
      1'b1 |=> (res_valid == $past(s1_valid))
   );

   // No result strobe straight out of reset
   a_res_reset : assert property
   (
      @(posedge clk) !rst_n |=> !res_valid
   );

endmodule

/* locked_alu_top.sv */
`timescale 1ns/1ps

`include "chaos_params.svh"

// Key-locked add/subtract unit
// Result appears two cycles after the request strobe
module locked_alu_top
(
   input  logic                      clk,
   input  logic                      rst_n,
   // Key segment write
   input  logic                      key_wr,
   input  logic                      key_seg,
   input  logic [`CHAOS_KEYSIZE-1:0] key_data,
   // Operation request
   input  logic                      op_valid,
   input  logic                      op_sub,
   input  logic [`CHAOS_WIDTH-1:0]   op_a,
   input  logic [`CHAOS_WIDTH-1:0]   op_b,
   // Result
   output logic                      res_valid,
   output logic [`CHAOS_WIDTH-1:0]   res
);

   chaos_pkg::key_t key;

   alu_op_if op_if ();

   // Plain ports onto the request bus
   assign op_if.valid = op_valid;
   assign op_if.op    = op_sub ? chaos_pkg::OP_SUB : chaos_pkg::OP_ADD;
   assign op_if.a     = op_a;
   assign op_if.b     = op_b;

   key_store u_key_store
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .key_wr   (key_wr),
      .key_seg  (key_seg),
      .key_data (key_data),
      .key      (key)
   );

   alu_stage u_alu_stage
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (op_if.dst),
      .key       (key),
      .res_valid (res_valid),
      .res       (res)
   );

endmodule

/* alu_checker.sv */
`timescale 1ns/1ps

`include "chaos_params.svh"

// Watches the DUT ports and predicts each result
// from a bit-level model of the locked adder
module alu_checker
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      key_wr,
   input  logic                      key_seg,
   input  logic [`CHAOS_KEYSIZE-1:0] key_data,
   input  logic                      op_valid,
   input  logic                      op_sub,
   input  logic [`CHAOS_WIDTH-1:0]   op_a,
   input  logic [`CHAOS_WIDTH-1:0]   op_b,
   input  logic                      res_valid,
   input  logic [`CHAOS_WIDTH-1:0]   res,
   output int                        errors,
   output int                        pending
);

   // Shadow of the key register
   logic [`CHAOS_KEYBITS-1:0] key_copy;
   // Expected results and their entry cycles, oldest first
   logic [`CHAOS_WIDTH-1:0]   exp_q[$];
   int                        entry_q[$];
   int                        cycle;
   logic [`CHAOS_WIDTH-1:0]   exp_v;
   int                        entry_v;

   // Gate output from a truth table indexed by {x, y}
   function automatic logic gate_out(input logic [1:0] fn, input logic x, input logic y);
      logic [3:0] tt;
      case (fn)
         2'd0:    tt = 4'b0110;
         2'd1:    tt = 4'b1000;
         2'd2:    tt = 4'b1110;
         default: tt = 4'b1001;
      endcase
      return tt[{x, y}];
   endfunction

   //////////////////////////////////////////////////
   // Ripple model
   //////////////////////////////////////////////////

   // Subtraction as inverted b plus a carry of one
   function automatic logic [`CHAOS_WIDTH-1:0] predict
   (
      input logic [`CHAOS_WIDTH-1:0]   a,
      input logic [`CHAOS_WIDTH-1:0]   b,
      input logic                      sub,
      input logic [`CHAOS_KEYBITS-1:0] key
   );
      logic [`CHAOS_WIDTH-1:0]   s;
      logic [`CHAOS_KEYSIZE-1:0] seg;
      logic                      c;
      logic                      p;
      int                        i;
      c = sub;
      for (i = 0; i < `CHAOS_WIDTH; i++)
      begin
         // Low half from segment 0
         seg  = (i < `CHAOS_WIDTH / 2) ? key[`CHAOS_KEYSIZE-1:0]
                                       : key[`CHAOS_KEYBITS-1:`CHAOS_KEYSIZE];
         p    = gate_out(seg[1:0], a[i], b[i] ^ sub);
         s[i] = gate_out(seg[3:2], p, c);
         // Carry rule fixed, final carry dropped
         c    = gate_out(seg[5:4], a[i], b[i] ^ sub) | (p & c);
      end
      return s;
   endfunction

   always @(posedge clk)
   begin
      if (!rst_n)
      begin
         key_copy = '0;
         exp_q.delete();
         entry_q.delete();
         cycle    = 0;
         errors   = 0;
      end
      else
      begin
         if (res_valid)
         begin
            if (exp_q.size() == 0)
            begin
               errors++;
               $display("Error at %0t: res_valid high with no operation outstanding", $time);
            end
            else
            begin
               exp_v   = exp_q.pop_front();
               entry_v = entry_q.pop_front();
               if (cycle - entry_v != 2)
               begin
                  errors++;
                  $display("Result at %0t came %0d cycles after its operation",
                           $time, cycle - entry_v);
               end
               if (res !== exp_v)
               begin
                  errors++;
                  $display("Error at %0t: res expected %h actual %h", $time, exp_v, res);
               end
            end
         end
         // Head overdue
         if (entry_q.size() != 0 && cycle - entry_q[0] >= 2)
         begin
            errors++;
            $display("Operation from cycle %0d got no result in time", entry_q[0]);
            void'(exp_q.pop_front());
            void'(entry_q.pop_front());
         end
         // New key visible to an operation entering at this same edge
         if (key_wr)
            key_copy[int'(key_seg)*`CHAOS_KEYSIZE +: `CHAOS_KEYSIZE] = key_data;
         if (op_valid)
         begin
            exp_q.push_back(predict(op_a, op_b, op_sub, key_copy));
            entry_q.push_back(cycle);
         end
         cycle++;
      end
      pending = exp_q.size();
   end

endmodule

/* tb_locked_alu.sv */
`timescale 1ns/1ps

`include "chaos_params.svh"

module tb_locked_alu;

   logic                      clk;
   logic                      rst_n;
   logic                      key_wr;
   logic                      key_seg;
   logic [`CHAOS_KEYSIZE-1:0] key_data;
   logic                      op_valid;
   logic                      op_sub;
   logic [`CHAOS_WIDTH-1:0]   op_a;
   logic [`CHAOS_WIDTH-1:0]   op_b;
   logic                      res_valid;
   logic [`CHAOS_WIDTH-1:0]   res;
   int                        chk_errors;
   int                        pending;
   int                        timeouts;
   int                        fd;
   int                        code;
   int                        wait_cnt;
   bit                        open_fail;
   string                     line;
   byte                       kind;
   logic [31:0]               f1;
   logic [31:0]               f2;
   logic [31:0]               f3;

   // 10 ns clock
   always #5 clk = ~clk;

   locked_alu_top u_dut (.*);

   alu_checker u_chk (.*, .errors(chk_errors));

   initial
   begin
      clk       = 1'b0;
      rst_n     = 1'b0;
      key_wr    = 1'b0;
      key_seg   = 1'b0;
      key_data  = '0;
      op_valid  = 1'b0;
      op_sub    = 1'b0;
      op_a      = '0;
      op_b      = '0;
      timeouts  = 0;
      open_fail = 1'b0;
      void'($urandom(32'h07cc_6039));
      repeat (5) @(posedge clk);
      #1 rst_n = 1'b1;

      //////////////////////////////////////////////////
      // One file line per cycle
      //////////////////////////////////////////////////
      fd = $fopen("locked_alu_tests.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the stimulus file locked_alu_tests.txt");
         open_fail = 1'b1;
      end
      else
      begin
         while (!$feof(fd))
         begin
            code = $fgets(line, fd);
            // Comment and blank lines take no cycle
            if (code > 0 && line.len() > 2 && line.getc(0) != "#")
            begin
               kind = line.getc(0);
               code = $sscanf(line.substr(2, line.len() - 1), "%h %h %h", f1, f2, f3);
               @(posedge clk);
               #1;
               key_wr   = (kind == "K");
               key_seg  = f1[0];
               key_data = f2[`CHAOS_KEYSIZE-1:0];
               op_valid = (kind == "O");
               op_sub   = f1[0];
               op_a     = f2;
               op_b     = f3;
            end
         end
         $fclose(fd);
         @(posedge clk);
         #1;
         key_wr   = 1'b0;
         op_valid = 1'b0;
         // Drain the pipeline
         wait_cnt = 0;
         while (pending != 0 && wait_cnt < 8)
         begin
            @(posedge clk);
            #1;
            wait_cnt++;
         end
         if (pending != 0)
         begin
            timeouts++;
            $display("Timeout with %0d operations still unanswered", pending);
         end
      end

      $display("Errors: checker %0d, timeouts %0d, file %0d", chk_errors, timeouts, open_fail);
      if (chk_errors == 0 && timeouts == 0 && !open_fail)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

/* sim.f */
+incdir+.
chaos_pkg.sv
alu_op_if.sv
adder_chaos.sv
add_sub_chaos.sv
key_store.sv
alu_stage.sv
locked_alu_top.sv
alu_checker.sv
tb_locked_alu.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert -f sim.f --top-module tb_locked_alu -o tb_sim \
   && ./obj_dir/tb_sim | tee /dev/stderr | grep -qx "Test OK" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

/* locked_alu_tests.txt */
# K seg data_hex       write one key segment
# O sub a_hex b_hex    one operation, sub 1 means a - b
# All-zero key after reset
O 0 00000005 00000003
O 1 12345678 0000ffff
# Correct key in both segments
K 0 10
K 1 10
O 0 00000001 00000002
O 0 0000ffff 00000001
O 0 ffffffff 00000001
O 0 89abcdef 76543210
O 1 00000010 00000003
O 1 00000003 00000010
O 1 abcdef01 abcdef01
O 1 00010000 00000001
# Segment 1 wrong, then segment 0 wrong
K 1 3c
O 0 1234ffff 0000f00f
O 1 80000000 00000001
K 1 10
K 0 2d
O 0 1234ffff 0000f00f
# Key change right behind an operation in flight
O 0 00ff00ff 00ff00ff
K 0 10
O 0 00ff00ff 00ff00ff
O 1 00000000 00000001
